/* bench/rom_loader_chk.sv */
/*
 * ROM loader checker.
 * Assertions on the request toggles and the reset and error outputs.
 */

`timescale 1ns/100ps
`default_nettype none

module rom_loader_chk (
	input logic clk_sd,
	input logic reset,
	input logic dl_active,
	input logic cpu_req,
	input logic spr_req,
	input logic rom_loaded,
	input logic core_reset,
	input logic load_error
);

	// Requests only move while a download is running
	cpu_req_idle: assert property (@(posedge clk_sd) disable iff (reset)
		!dl_active |-> $stable(cpu_req))
		else $error("cpu_req toggled while dl_active was low");

	spr_req_idle: assert property (@(posedge clk_sd) disable iff (reset)
		!dl_active |-> $stable(spr_req))
		else $error("spr_req toggled while dl_active was low");

	core_held: assert property (@(posedge clk_sd) disable iff (reset)
		!rom_loaded |-> core_reset)
		else $error("core_reset low although rom_loaded is low");

	// Load error is sticky until the next reset
	error_sticky: assert property (@(posedge clk_sd)
		$fell(load_error) |-> $past(reset))
		else $error("load_error cleared without reset");

endmodule

bind rom_loader rom_loader_chk u_chk (
	.clk_sd     (clk_sd),
	.reset      (reset),
	.dl_active  (dl_active),
	.cpu_req    (cpu_req),
	.spr_req    (spr_req),
	.rom_loaded (rom_loaded),
	.core_reset (core_reset),
	.load_error (load_error)
);

`default_nettype wire

/* bench/tb_rom_loader.sv */
/*
 * ROM loader testbench.
 * Applies a download table to both lanes with random acknowledge delays,
 * then checks overrun, loaded status and the core reset hold.
 */

`timescale 1ns/100ps
`default_nettype none
`include "rom_loader_defs.svh"

module tb_rom_loader
	import rom_loader_pkg::*;
();

	localparam int N_ROWS = 14;
	localparam int MAX_ACK = 4;
	localparam int LONG_ACK = 20;

	// Byte address, data byte and cycles until the next strobe
	localparam logic [48:0] DL_TABLE [N_ROWS] = '{
		{25'h00000, 8'h11, 16'd2},
		{25'h00001, 8'h22, 16'd8},
		{25'h16000, 8'h33, 16'd2},
		{25'h1A000, 8'h44, 16'd8},
		{25'h0ABCD, 8'h55, 16'd3},
		{25'h1E123, 8'h66, 16'd6},
		{25'h22000, 8'h77, 16'd3},
		{25'h15FFF, 8'h88, 16'd2},
		{25'h1F456, 8'h99, 16'd8},
		{25'h21FFF, 8'hAA, 16'd4},
		{25'h1A001, 8'hBB, 16'd8},
		{25'h30000, 8'hCC, 16'd3},
		{25'h01234, 8'hDD, 16'd2},
		{25'h0FFFE, 8'hEE, 16'd4}
	};

	logic      clk_sd;
	logic      reset;
	logic      dl_active;
	logic      dl_wr;
	dl_addr_t  dl_addr;
	dl_byte_t  dl_data;
	logic      reset_req;
	logic      cpu_req;
	logic      cpu_ack;
	mem_addr_t cpu_addr;
	byte_sel_t cpu_ds;
	mem_word_t cpu_data;
	logic      spr_req;
	logic      spr_ack;
	mem_addr_t spr_addr;
	byte_sel_t spr_ds;
	mem_word_t spr_data;
	logic      rom_loaded;
	logic      core_reset;
	logic      load_error;

	// Expected writes packed as word address, byte selects and data word
	logic [40:0] cpu_exp [$];
	logic [40:0] spr_exp [$];
	logic        cpu_req_seen;
	logic        spr_req_seen;
	logic        long_ack;
	logic [31:0] rng;
	int          cpu_wait;
	int          spr_wait;
	int          cycles;
	int          timeout_limit;

	rom_loader i_dut (.*);

	initial begin
		clk_sd = 1'b0;
		forever #10 clk_sd = ~clk_sd;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	function automatic int ack_delay();
		rng = xorshift(rng);
		if (long_ack)
			return LONG_ACK;
		return 1 + int'(rng % MAX_ACK);
	endfunction

	// Word address is the byte address halved and odd bytes take the upper select
	function automatic logic [40:0] cpu_expect(input dl_addr_t a, input dl_byte_t d);
		int unsigned w;
		byte_sel_t   s;
		w = a / 2;
		s = (a % 2 == 1) ? 2'b10 : 2'b01;
		return {mem_addr_t'(w), s, d, d};
	endfunction

	// Offset bits 23 to 16, 13 to 0 and 15 form the word address and bit 14 selects the byte
	function automatic logic [40:0] spr_expect(input dl_addr_t a, input dl_byte_t d);
		int unsigned off;
		int unsigned w;
		byte_sel_t   s;
		off = a - `SPR_REGION_BASE;
		w = ((off / 65536) % 256) * 32768 + (off % 16384) * 2 + (off / 32768) % 2;
		s = ((off / 16384) % 2 == 1) ? 2'b10 : 2'b01;
		return {mem_addr_t'(w), s, d, d};
	endfunction

	// ========================================
	// Error reporting and compare tasks
	// ========================================

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %0t %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	task automatic check_ds(input string name, input byte_sel_t exp, input byte_sel_t act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %0t %s expected %b actual %b",
				$time, name, exp, act));
	endtask

	task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %0t %s expected %h actual %h",
				$time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act)
			abort_run($sformatf("[FAIL] %0t %s expected %b actual %b",
				$time, name, exp, act));
	endtask

	task automatic check_write(input string port, input logic [40:0] e,
		input mem_addr_t a, input byte_sel_t ds, input mem_word_t d);
		check_addr({port, "_addr"}, e[40:18], a);
		check_ds({port, "_ds"}, e[17:16], ds);
		check_word({port, "_data"}, e[15:0], d);
	endtask

	// ========================================
	// Stimulus helpers
	// ========================================

	task automatic expect_row(input dl_addr_t a, input dl_byte_t d);
		if (a < `CPU_REGION_END)
			cpu_exp.push_back(cpu_expect(a, d));
		else if (a < `SPR_REGION_END)
			spr_exp.push_back(spr_expect(a, d));
	endtask

	// Called 2 ns after a rising edge and returns at the same phase
	task automatic apply_row(input dl_addr_t a, input dl_byte_t d, input int gap);
		dl_addr = a;
		dl_data = d;
		dl_wr = 1'b1;
		@(posedge clk_sd);
		#2;
		dl_wr = 1'b0;
		repeat (gap - 1) begin
			@(posedge clk_sd);
			#2;
		end
	endtask

	task automatic wait_issued();
		while (cpu_exp.size() != 0 || spr_exp.size() != 0)
			@(posedge clk_sd);
		@(posedge clk_sd);
		#2;
	endtask

	// Starts at the negedge after the last reset condition was sampled
	task automatic check_release();
		repeat (`RESET_HOLD - 1) @(negedge clk_sd);
		check_bit("core_reset", 1'b1, core_reset);
		@(negedge clk_sd);
		check_bit("core_reset", 1'b0, core_reset);
	endtask

	// Each toggle must match the oldest expected write of its lane
	always @(negedge clk_sd) begin
		if (!reset && cpu_req !== cpu_req_seen) begin
			cpu_req_seen = cpu_req;
			if (cpu_exp.size() == 0)
				abort_run("Unexpected write issued on the CPU port");
			else
				check_write("cpu", cpu_exp.pop_front(), cpu_addr, cpu_ds, cpu_data);
		end
		if (!reset && spr_req !== spr_req_seen) begin
			spr_req_seen = spr_req;
			if (spr_exp.size() == 0)
				abort_run("Unexpected write issued on the sprite port");
			else
				check_write("spr", spr_exp.pop_front(), spr_addr, spr_ds, spr_data);
		end
	end

	// Memory side answers each toggle after a random number of cycles
	initial begin
		cpu_ack = 1'b0;
		spr_ack = 1'b0;
		cpu_wait = 0;
		spr_wait = 0;
		forever begin
			@(posedge clk_sd);
			#2;
			if (cpu_wait > 0) begin
				cpu_wait--;
				if (cpu_wait == 0)
					cpu_ack = cpu_req;
			end else if (cpu_req !== cpu_ack)
				cpu_wait = ack_delay();
			if (spr_wait > 0) begin
				spr_wait--;
				if (spr_wait == 0)
					spr_ack = spr_req;
			end else if (spr_req !== spr_ack)
				spr_wait = ack_delay();
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk_sd);
			cycles++;
			if (cycles > timeout_limit) begin
				$display("Timeout after %0d cycles, the DUT never finished", cycles);
				$display("Test failed");
				$fatal(1, "timeout");
			end
		end
	end

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		int       i;
		dl_addr_t ovr_addr;
		dl_byte_t ovr_data;
		reset = 1'b1;
		dl_active = 1'b0;
		dl_wr = 1'b0;
		dl_addr = '0;
		dl_data = '0;
		reset_req = 1'b0;
		cpu_req_seen = 1'b0;
		spr_req_seen = 1'b0;
		long_ack = 1'b0;
		rng = 32'd30;
		timeout_limit = 5 + N_ROWS * (MAX_ACK + 2) + 3 * (LONG_ACK + 2);
		timeout_limit += 4 * `RESET_HOLD + 100;
		for (i = 0; i < N_ROWS; i++)
			timeout_limit += int'(DL_TABLE[i][15:0]);

		repeat (5) @(posedge clk_sd);
		#2;
		reset = 1'b0;
		// An idle edge out of reset must not mark the ROM as loaded
		@(posedge clk_sd);
		@(negedge clk_sd);
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("rom_loaded", 1'b0, rom_loaded);
		check_bit("load_error", 1'b0, load_error);

		// Whole table as one download
		@(posedge clk_sd);
		#2;
		dl_active = 1'b1;
		@(posedge clk_sd);
		#2;
		for (i = 0; i < N_ROWS; i++) begin
			expect_row(DL_TABLE[i][48:24], DL_TABLE[i][23:16]);
			apply_row(DL_TABLE[i][48:24], DL_TABLE[i][23:16], int'(DL_TABLE[i][15:0]));
		end
		wait_issued();
		dl_active = 1'b0;
		while (!rom_loaded)
			@(negedge clk_sd);
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("load_error", 1'b0, load_error);
		check_release();

		// Game core reset request after loading
		@(posedge clk_sd);
		#2;
		reset_req = 1'b1;
		repeat (3) @(posedge clk_sd);
		#2;
		reset_req = 1'b0;
		@(negedge clk_sd);
		check_bit("core_reset", 1'b1, core_reset);
		check_bit("rom_loaded", 1'b1, rom_loaded);
		check_release();

		// Second download with a slow memory so the third write is lost
		@(posedge clk_sd);
		#2;
		dl_active = 1'b1;
		@(posedge clk_sd);
		@(negedge clk_sd);
		check_bit("rom_loaded", 1'b0, rom_loaded);
		check_bit("core_reset", 1'b1, core_reset);
		long_ack = 1'b1;
		@(posedge clk_sd);
		#2;
		for (i = 0; i < 3; i++) begin
			ovr_addr = 25'h00100 + dl_addr_t'(i);
			ovr_data = 8'hA0 + dl_byte_t'(i);
			if (i < 2)
				expect_row(ovr_addr, ovr_data);
			apply_row(ovr_addr, ovr_data, 2);
		end
		wait_issued();
		check_bit("load_error", 1'b1, load_error);
		dl_active = 1'b0;
		while (!rom_loaded)
			@(negedge clk_sd);
		check_bit("load_error", 1'b1, load_error);

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build the ROM loader testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rom_loader -f src.f -o tb_rom_loader

status=0
./obj_dir/tb_rom_loader > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished cleanly"

/* source/cpu_rom_lane.sv */
/*
 * CPU ROM lane.
 * Turns download bytes of the program and gfx1 region into toggled
 * 16-bit memory writes, with one issued and one held write.
 */

`timescale 1ns/100ps
`default_nettype none
`include "rom_loader_defs.svh"

module cpu_rom_lane
	import rom_loader_pkg::*;
(
	input  logic      clk_sd,
	input  logic      reset,
	input  logic      dl_active,
	input  logic      dl_wr,
	input  dl_addr_t  dl_addr,
	input  dl_byte_t  dl_data,
	output logic      mem_req,
	input  logic      mem_ack,
	output mem_addr_t mem_addr,
	output byte_sel_t mem_ds,
	output mem_word_t mem_data,
	output logic      busy,
	output logic      overrun
);

	logic      dl_wr_last;
	logic      hit;
	logic      outstanding;
	logic      stage_valid;
	mem_addr_t stage_addr;
	byte_sel_t stage_ds;
	mem_word_t stage_data;
	logic      hold_valid;
	mem_addr_t hold_addr;
	byte_sel_t hold_ds;
	mem_word_t hold_data;
	logic      issue_hold;
	logic      issue_stage;
	logic      load_hold;
	logic      drop;

	// Rising strobe on a byte that belongs to this lane
	assign hit = dl_active && dl_wr && !dl_wr_last && (dl_addr < `CPU_REGION_END);

	assign outstanding = mem_req ^ mem_ack;
	assign busy = outstanding | hold_valid | stage_valid;

	// The held write always goes out before a newer staged one
	assign issue_hold = !outstanding && hold_valid;
	assign issue_stage = !outstanding && !hold_valid && stage_valid;
	assign load_hold = stage_valid && (outstanding ? !hold_valid : hold_valid);
	assign drop = stage_valid && outstanding && hold_valid;

	always_ff @(posedge clk_sd) begin
		if (reset) begin
			dl_wr_last <= 1'b0;
			stage_valid <= 1'b0;
			hold_valid <= 1'b0;
			mem_req <= 1'b0;
			mem_addr <= '0;
			mem_ds <= '0;
			mem_data <= '0;
			overrun <= 1'b0;
		end else begin
			dl_wr_last <= dl_wr;
			stage_valid <= hit;
			if (issue_hold || issue_stage)
				mem_req <= ~mem_req;
			if (issue_hold) begin
				mem_addr <= hold_addr;
				mem_ds <= hold_ds;
				mem_data <= hold_data;
			end else if (issue_stage) begin
				mem_addr <= stage_addr;
				mem_ds <= stage_ds;
				mem_data <= stage_data;
			end
			if (load_hold)
				hold_valid <= 1'b1;
			else if (issue_hold)
				hold_valid <= 1'b0;
			if (drop)
				overrun <= 1'b1;
		end
	end

	// Word address is the byte address halved and odd bytes go to the upper half
	always_ff @(posedge clk_sd) begin
		if (hit) begin
			stage_addr <= dl_addr[23:1];
			stage_ds <= {dl_addr[0], ~dl_addr[0]};
			stage_data <= {dl_data, dl_data};
		end
		if (load_hold) begin
			hold_addr <= stage_addr;
			hold_ds <= stage_ds;
			hold_data <= stage_data;
		end
	end

endmodule

`default_nettype wire

/* source/load_supervisor.sv */
/*
 * Load supervisor.
 * Marks the ROM as loaded once both lanes drain, keeps the game core
 * in reset for a fixed time afterwards and collects lane overruns.
 */

`timescale 1ns/100ps
`default_nettype none
`include "rom_loader_defs.svh"

module load_supervisor (
	input  logic clk_sd,
	input  logic reset,
	input  logic dl_active,
	input  logic reset_req,
	input  logic cpu_busy,
	input  logic spr_busy,
	input  logic cpu_overrun,
	input  logic spr_overrun,
	output logic rom_loaded,
	output logic core_reset,
	output logic load_error
);

	localparam int HOLD_W = $clog2(`RESET_HOLD + 1);

	logic              dl_active_last;
	logic              dl_seen;
	logic              dl_rise;
	logic              drained;
	logic [HOLD_W-1:0] hold_cnt;

	assign dl_rise = dl_active && !dl_active_last;
	assign drained = !dl_active && !cpu_busy && !spr_busy && dl_seen;

	// ========================================
	// Download tracking
	// ========================================

	always_ff @(posedge clk_sd) begin
		if (reset) begin
			dl_active_last <= 1'b0;
			dl_seen <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			dl_active_last <= dl_active;
			if (dl_active)
				dl_seen <= 1'b1;
			// A fresh download invalidates the loaded image
			if (dl_rise)
				rom_loaded <= 1'b0;
			else if (drained)
				rom_loaded <= 1'b1;
		end
	end

	// ========================================
	// Core reset hold
	// ========================================

	// Reloaded on every cycle a reset condition holds, then counts out
	always_ff @(posedge clk_sd) begin
		if (reset)
			hold_cnt <= HOLD_W'(`RESET_HOLD);
		else if (!rom_loaded || reset_req)
			hold_cnt <= HOLD_W'(`RESET_HOLD);
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign core_reset = !rom_loaded || reset_req || (hold_cnt != '0);

	always_ff @(posedge clk_sd) begin
		if (reset)
			load_error <= 1'b0;
		else if (cpu_overrun || spr_overrun)
			load_error <= 1'b1;
	end

endmodule

`default_nettype wire

/* source/rom_loader.sv */
/*
 * ROM download path.
 * Two lanes turn the loader byte stream into memory writes and a
 * supervisor derives loaded status, core reset and load error.
 */

`timescale 1ns/100ps
`default_nettype none

module rom_loader
	import rom_loader_pkg::*;
(
	input  logic      clk_sd,
	input  logic      reset,
	input  logic      dl_active,
	input  logic      dl_wr,
	input  dl_addr_t  dl_addr,
	input  dl_byte_t  dl_data,
	input  logic      reset_req,
	output logic      cpu_req,
	input  logic      cpu_ack,
	output mem_addr_t cpu_addr,
	output byte_sel_t cpu_ds,
	output mem_word_t cpu_data,
	output logic      spr_req,
	input  logic      spr_ack,
	output mem_addr_t spr_addr,
	output byte_sel_t spr_ds,
	output mem_word_t spr_data,
	output logic      rom_loaded,
	output logic      core_reset,
	output logic      load_error
);

	logic cpu_busy;
	logic cpu_overrun;
	logic spr_busy;
	logic spr_overrun;

	// Main and sound program plus gfx1
	cpu_rom_lane u_cpu_lane (
		.clk_sd    (clk_sd),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.mem_req   (cpu_req),
		.mem_ack   (cpu_ack),
		.mem_addr  (cpu_addr),
		.mem_ds    (cpu_ds),
		.mem_data  (cpu_data),
		.busy      (cpu_busy),
		.overrun   (cpu_overrun)
	);

	// Sprite graphics merged into 32-bit words
	sprite_rom_lane u_spr_lane (
		.clk_sd    (clk_sd),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_wr     (dl_wr),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.mem_req   (spr_req),
		.mem_ack   (spr_ack),
		.mem_addr  (spr_addr),
		.mem_ds    (spr_ds),
		.mem_data  (spr_data),
		.busy      (spr_busy),
		.overrun   (spr_overrun)
	);

	load_supervisor u_supervisor (
		.clk_sd      (clk_sd),
		.reset       (reset),
		.dl_active   (dl_active),
		.reset_req   (reset_req),
		.cpu_busy    (cpu_busy),
		.spr_busy    (spr_busy),
		.cpu_overrun (cpu_overrun),
		.spr_overrun (spr_overrun),
		.rom_loaded  (rom_loaded),
		.core_reset  (core_reset),
		.load_error  (load_error)
	);

endmodule

`default_nettype wire

/* source/rom_loader_defs.svh */
/*
 * ROM loader constants.
 * Byte address bounds of the download regions and the length
 * of the game core reset hold after loading.
 */

`ifndef ROM_LOADER_DEFS_SVH
`define ROM_LOADER_DEFS_SVH

// Main CPU, sound CPU and gfx1 occupy everything below this address
`define CPU_REGION_END 25'h16000

// Sprite graphics from six ROMs merged into 32-bit fetches
`define SPR_REGION_BASE 25'h16000
`define SPR_REGION_END 25'h22000

// Cycles of clk_sd that core_reset stays high after the last reset condition
`define RESET_HOLD 16

`endif

/* source/rom_loader_pkg.sv */
/*
 * ROM loader types.
 * Download stream and memory write port types shared by the lanes.
 */

`default_nettype none

package rom_loader_pkg;

	// Byte address as delivered by the loader
	typedef logic [24:0] dl_addr_t;

	// One byte of the download stream
	typedef logic [7:0] dl_byte_t;

	// Word address on the memory write ports
	typedef logic [22:0] mem_addr_t;

	// Data word on the memory write ports
	typedef logic [15:0] mem_word_t;

	// Upper select in bit 1, lower select in bit 0
	typedef logic [1:0] byte_sel_t;

endpackage

`default_nettype wire

/* source/sprite_rom_lane.sv */
/*
 * Sprite ROM lane.
 * Remaps sprite region bytes so the sprite ROMs merge into 32-bit
 * fetches, and issues them as toggled 16-bit memory writes.
 */

`timescale 1ns/100ps
`default_nettype none
`include "rom_loader_defs.svh"

module sprite_rom_lane
	import rom_loader_pkg::*;
(
	input  logic      clk_sd,
	input  logic      reset,
	input  logic      dl_active,
	input  logic      dl_wr,
	input  dl_addr_t  dl_addr,
	input  dl_byte_t  dl_data,
	output logic      mem_req,
	input  logic      mem_ack,
	output mem_addr_t mem_addr,
	output byte_sel_t mem_ds,
	output mem_word_t mem_data,
	output logic      busy,
	output logic      overrun
);

	logic      dl_wr_last;
	logic      in_region;
	logic      hit;
	dl_addr_t  spr_offset;
	logic      outstanding;
	logic      stage_valid;
	mem_addr_t stage_addr;
	byte_sel_t stage_ds;
	mem_word_t stage_data;
	logic      hold_valid;
	mem_addr_t hold_addr;
	byte_sel_t hold_ds;
	mem_word_t hold_data;
	logic      issue_hold;
	logic      issue_stage;
	logic      load_hold;
	logic      drop;

	// Palette and lookup bytes above the region are not taken
	assign in_region = (dl_addr >= `SPR_REGION_BASE) && (dl_addr < `SPR_REGION_END);
	assign hit = dl_active && dl_wr && !dl_wr_last && in_region;
	assign spr_offset = dl_addr - `SPR_REGION_BASE;

	assign outstanding = mem_req ^ mem_ack;
	assign busy = outstanding | hold_valid | stage_valid;

	assign issue_hold = !outstanding && hold_valid;
	assign issue_stage = !outstanding && !hold_valid && stage_valid;
	assign load_hold = stage_valid && (outstanding ? !hold_valid : hold_valid);
	assign drop = stage_valid && outstanding && hold_valid;

	// ========================================
	// Request toggle and hold control
	// ========================================

	always_ff @(posedge clk_sd) begin
		if (reset) begin
			dl_wr_last <= 1'b0;
			stage_valid <= 1'b0;
			hold_valid <= 1'b0;
			mem_req <= 1'b0;
			mem_addr <= '0;
			mem_ds <= '0;
			mem_data <= '0;
			overrun <= 1'b0;
		end else begin
			dl_wr_last <= dl_wr;
			stage_valid <= hit;
			if (issue_hold || issue_stage)
				mem_req <= ~mem_req;
			if (issue_hold) begin
				mem_addr <= hold_addr;
				mem_ds <= hold_ds;
				mem_data <= hold_data;
			end else if (issue_stage) begin
				mem_addr <= stage_addr;
				mem_ds <= stage_ds;
				mem_data <= stage_data;
			end
			if (load_hold)
				hold_valid <= 1'b1;
			else if (issue_hold)
				hold_valid <= 1'b0;
			if (drop)
				overrun <= 1'b1;
		end
	end

	// ========================================
	// Address interleave
	// ========================================

	// Offset bit 15 picks the word within a 32-bit pair and bit 14 the byte
	always_ff @(posedge clk_sd) begin
		if (hit) begin
			stage_addr <= {spr_offset[23:16], spr_offset[13:0], spr_offset[15]};
			stage_ds <= {spr_offset[14], ~spr_offset[14]};
			stage_data <= {dl_data, dl_data};
		end
		if (load_hold) begin
			hold_addr <= stage_addr;
			hold_ds <= stage_ds;
			hold_data <= stage_data;
		end
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/rom_loader_pkg.sv
source/cpu_rom_lane.sv
source/sprite_rom_lane.sv
source/load_supervisor.sv
source/rom_loader.sv
bench/rom_loader_chk.sv
bench/tb_rom_loader.sv
